// ==== design/calc_pkg.sv ====
package calc_pkg;

    ////////////////////////////////////////////////////////////
    // Operation switches, one-hot, add on the leftmost switch
    ////////////////////////////////////////////////////////////
    localparam logic [10:0] OP_ADD = 11'b100_0000_0000;
    localparam logic [10:0] OP_SUB = 11'b010_0000_0000;
    localparam logic [10:0] OP_MUL = 11'b001_0000_0000;
    localparam logic [10:0] OP_DIV = 11'b000_1000_0000;
    localparam logic [10:0] OP_AND = 11'b000_0100_0000;
    localparam logic [10:0] OP_OR  = 11'b000_0010_0000;
    localparam logic [10:0] OP_XOR = 11'b000_0001_0000;
    localparam logic [10:0] OP_NOT = 11'b000_0000_1000;
    localparam logic [10:0] OP_SHL = 11'b000_0000_0100;
    localparam logic [10:0] OP_SHR = 11'b000_0000_0010;
    localparam logic [10:0] OP_CMP = 11'b000_0000_0001;

    // Action chosen by the two selection switches
    localparam logic [1:0] SEL_LOAD_A  = 2'd0;
    localparam logic [1:0] SEL_LOAD_B  = 2'd1;
    localparam logic [1:0] SEL_COMPUTE = 2'd2;
    localparam logic [1:0] SEL_IDLE    = 2'd3;

    // Divide fills the two halves, everything else the full word
    typedef union packed {
        logic [31:0] word;
        struct packed {
            logic [15:0] remainder;  // Upper half
            logic [15:0] quotient;   // Lower half
        } div;
    } calc_result_t;

    ////////////////////////////////////////////////////////////
    // Display
    ////////////////////////////////////////////////////////////
    localparam int NUM_DIGITS       = 8;
    localparam int SCAN_BITS        = 10;      // 2^10 cycles per digit
    localparam int DEBOUNCE_DEFAULT = 100000;  // 1 ms at 100 MHz

    // Hex font, active low, bit order gfedcba
    function automatic logic [6:0] seg_font(input logic [3:0] nibble);
        case (nibble)
            4'h0: seg_font = 7'b1000000;
            4'h1: seg_font = 7'b1111001;
            4'h2: seg_font = 7'b0100100;
            4'h3: seg_font = 7'b0110000;
            4'h4: seg_font = 7'b0011001;
            4'h5: seg_font = 7'b0010010;
            4'h6: seg_font = 7'b0000010;
            4'h7: seg_font = 7'b1111000;
            4'h8: seg_font = 7'b0000000;
            4'h9: seg_font = 7'b0010000;
            4'hA: seg_font = 7'b0001000;
            4'hB: seg_font = 7'b0000011;  // Lower case b
            4'hC: seg_font = 7'b1000110;
            4'hD: seg_font = 7'b0100001;  // Lower case d
            4'hE: seg_font = 7'b0000110;
            default: seg_font = 7'b0001110;  // F
        endcase
    endfunction

endpackage

// ==== design/button_debouncer.sv ====
`timescale 1ns/1ps

module button_debouncer #(
    parameter int STABLE_CYCLES = 100000
) (
    input  logic CLK100MHz,
    input  logic reset,
    input  logic btn,
    output logic press
);

    logic                                   btn_meta;
    logic                                   btn_sync;
    logic [$clog2(STABLE_CYCLES + 1) - 1:0] stable_cnt;
    logic                                   level;      // Accepted button level
    logic                                   level_d;

    ////////////////////////////////////////////////////////////
    // Two-flop synchronizer
    ////////////////////////////////////////////////////////////
    always_ff @(posedge CLK100MHz or posedge reset) begin
        if (reset) begin
            btn_meta <= 1'b0;
            btn_sync <= 1'b0;
        end else begin
            btn_meta <= btn;
            btn_sync <= btn_meta;
        end
    end

    // Count how long the synchronized level has differed from the accepted one.
    // Any return to the accepted level, even for one cycle, starts over.
    always_ff @(posedge CLK100MHz or posedge reset) begin
        if (reset) begin
            stable_cnt <= '0;
            level      <= 1'b0;
        end else if (btn_sync == level) begin
            stable_cnt <= '0;
        end else if (stable_cnt == STABLE_CYCLES - 1) begin
            stable_cnt <= '0;
            level      <= btn_sync;  // New level has held long enough
        end else begin
            stable_cnt <= stable_cnt + 1'b1;
        end
    end

    // Edge detect on the accepted level
    always_ff @(posedge CLK100MHz or posedge reset) begin
        if (reset) begin
            level_d <= 1'b0;
            press   <= 1'b0;
        end else begin
            level_d <= level;
            press   <= level & ~level_d;  // One cycle per press
        end
    end

endmodule

// ==== design/arithmetic_unit.sv ====
`timescale 1ns/1ps

module arithmetic_unit import calc_pkg::*; (
    input  logic         CLK100MHz,
    input  logic         reset,
    input  logic         press,             // Debounced center button pulse
    input  logic [15:0]  input_data,
    input  logic [1:0]   operand_selection,
    input  logic [10:0]  operation,
    output calc_result_t result_out,
    output logic         result_ready_out
);

    logic [15:0]  operand_a;
    logic [15:0]  operand_b;
    calc_result_t result;
    logic         result_ready;

    calc_result_t next_result;
    logic         op_valid;   // Operation word is exactly one known code

    assign result_out       = result;
    assign result_ready_out = result_ready;

    ////////////////////////////////////////////////////////////
    // Combinational datapath, all eleven operations
    ////////////////////////////////////////////////////////////
    always_comb begin
        next_result = '0;
        op_valid    = 1'b1;
        unique case (operation)
            OP_ADD: next_result.word = 32'(operand_a) + 32'(operand_b);
            OP_SUB: next_result.word = 32'(operand_a) - 32'(operand_b);  // Wraps mod 2^32
            OP_MUL: next_result.word = 32'(operand_a) * 32'(operand_b);
            OP_DIV: begin
                if (operand_b == 16'd0) begin
                    next_result.div.quotient  = 16'hFFFF;
                    next_result.div.remainder = operand_a;
                end else begin
                    next_result.div.quotient  = operand_a / operand_b;
                    next_result.div.remainder = operand_a % operand_b;
                end
            end
            OP_AND: next_result.word = {16'd0, operand_a & operand_b};
            OP_OR:  next_result.word = {16'd0, operand_a | operand_b};
            OP_XOR: next_result.word = {16'd0, operand_a ^ operand_b};
            OP_NOT: next_result.word = {16'd0, ~operand_a};
            OP_SHL: next_result.word = 32'(operand_a) << operand_b[3:0];
            OP_SHR: next_result.word = 32'(operand_a) >> operand_b[3:0];
            OP_CMP: next_result.word = {31'd0, operand_a > operand_b};
            default: begin
                op_valid = 1'b0;  // None or several switches up
            end
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Operand and result registers
    ////////////////////////////////////////////////////////////
    // Nothing moves unless the button was pressed. A compute is taken once
    // per load; a new operand re-arms it.
    always_ff @(posedge CLK100MHz or posedge reset) begin
        if (reset) begin
            operand_a    <= 16'd0;
            operand_b    <= 16'd0;
            result       <= '0;
            result_ready <= 1'b0;
        end else if (press) begin
            case (operand_selection)
                SEL_LOAD_A: begin
                    operand_a    <= input_data;
                    result_ready <= 1'b0;
                end
                SEL_LOAD_B: begin
                    operand_b    <= input_data;
                    result_ready <= 1'b0;
                end
                SEL_COMPUTE: begin
                    if (!result_ready) begin
                        if (op_valid) begin
                            result       <= next_result;
                            result_ready <= 1'b1;
                        end else begin
                            result <= '0;  // Bad operation word, ready stays low
                        end
                    end
                end
                SEL_IDLE: begin
                    // Hold everything
                end
            endcase
        end
    end

    // Operation switches are expected to be set before the compute press.
    // They are sampled only at that edge, so moving them later has no
    // effect on a stored result.

endmodule

// ==== design/hex_display_scan.sv ====
`timescale 1ns/1ps

module hex_display_scan import calc_pkg::*; (
    input  logic        CLK100MHz,
    input  logic        reset,
    input  logic [31:0] value,
    output logic [6:0]  seg,    // Active low, gfedcba
    output logic [7:0]  an      // Active low digit enables
);

    logic [SCAN_BITS + $clog2(NUM_DIGITS) - 1:0] refresh_cnt;
    logic [$clog2(NUM_DIGITS) - 1:0]             digit_sel;
    logic [3:0]                                  nibble;

    ////////////////////////////////////////////////////////////
    // Refresh counter
    ////////////////////////////////////////////////////////////
    always_ff @(posedge CLK100MHz or posedge reset) begin
        if (reset) begin
            refresh_cnt <= '0;
        end else begin
            refresh_cnt <= refresh_cnt + 1'b1;  // Free running, wraps over all digits
        end
    end

    // Top bits of the counter walk through the digits
    assign digit_sel = refresh_cnt[SCAN_BITS +: $clog2(NUM_DIGITS)];

    // Digit 0 is the rightmost, least significant nibble
    assign nibble = value[digit_sel * 4 +: 4];

    ////////////////////////////////////////////////////////////
    // Output registers
    ////////////////////////////////////////////////////////////
    // seg and an come from the same edge so a digit never shows the
    // pattern of its neighbour
    always_ff @(posedge CLK100MHz or posedge reset) begin
        if (reset) begin
            an  <= ~8'd1;       // Digit 0 selected
            seg <= 7'b1111111;  // Blank
        end else begin
            an  <= ~(NUM_DIGITS'(1) << digit_sel);
            seg <= seg_font(nibble);
        end
    end

    // At 100 MHz each digit is lit for about 10 us, a full sweep
    // takes about 82 us, well above any visible flicker rate.

endmodule

// ==== design/calculator_top.sv ====
`timescale 1ns/1ps

module calculator_top import calc_pkg::*; #(
    parameter int DEBOUNCE_CYCLES = DEBOUNCE_DEFAULT
) (
    input  logic         CLK100MHz,
    input  logic         reset,
    input  logic [15:0]  input_data,         // Data switches
    input  logic [1:0]   operand_selection,  // Load A, load B or compute
    input  logic [10:0]  operation,          // One-hot operation switches
    input  logic         btn_c,              // Raw center button
    output calc_result_t result_out,
    output logic         result_ready_out,
    output logic [6:0]   seg,
    output logic [7:0]   an
);

    logic press;

    ////////////////////////////////////////////////////////////
    // Button, datapath and display
    ////////////////////////////////////////////////////////////
    button_debouncer #(
        .STABLE_CYCLES(DEBOUNCE_CYCLES)
    ) u_debouncer (
        .CLK100MHz(CLK100MHz),
        .reset    (reset),
        .btn      (btn_c),
        .press    (press)
    );

    arithmetic_unit u_arith (
        .CLK100MHz        (CLK100MHz),
        .reset            (reset),
        .press            (press),
        .input_data       (input_data),
        .operand_selection(operand_selection),
        .operation        (operation),
        .result_out       (result_out),
        .result_ready_out (result_ready_out)
    );

    hex_display_scan u_display (
        .CLK100MHz(CLK100MHz),
        .reset    (reset),
        .value    (result_out.word),  // Shown as plain hex, also for divide
        .seg      (seg),
        .an       (an)
    );

endmodule

// ==== verif/tb_calculator.sv ====
`timescale 1ns/1ps

module tb_calculator import calc_pkg::*;;

    // Budget for the watchdog, in clock cycles
    localparam int PRESS_BUDGET    = 64;
    localparam int PRESS_CYCLES    = 26;
    localparam int DIGIT_WAIT      = 2 * (NUM_DIGITS << SCAN_BITS);
    localparam int TEST_CYCLES     = 16 + PRESS_BUDGET * PRESS_CYCLES + 200
                                     + NUM_DIGITS * DIGIT_WAIT;
    localparam int WATCHDOG_CYCLES = TEST_CYCLES * 2 + 20000;

    logic         CLK100MHz;
    logic         reset;
    logic [15:0]  input_data;
    logic [1:0]   operand_selection;
    logic [10:0]  operation;
    logic         btn_c;
    calc_result_t result_out;
    logic         result_ready_out;
    logic [6:0]   seg;
    logic [7:0]   an;

    integer       seed;

    logic [10:0] op_list [11] = '{OP_ADD, OP_SUB, OP_MUL, OP_DIV, OP_AND, OP_OR,
                                  OP_XOR, OP_NOT, OP_SHL, OP_SHR, OP_CMP};
    string       op_names [11] = '{"add", "sub", "mul", "div", "and", "or",
                                   "xor", "not", "shl", "shr", "cmp"};

    calculator_top #(
        .DEBOUNCE_CYCLES(4)
    ) uut (
        .CLK100MHz        (CLK100MHz),
        .reset            (reset),
        .input_data       (input_data),
        .operand_selection(operand_selection),
        .operation        (operation),
        .btn_c            (btn_c),
        .result_out       (result_out),
        .result_ready_out (result_ready_out),
        .seg              (seg),
        .an               (an)
    );

    initial begin
        CLK100MHz = 1'b0;
        forever #5 CLK100MHz = ~CLK100MHz;  // 100 MHz
    end

    ////////////////////////////////////////////////////////////
    // Reference model from the arithmetic rules
    ////////////////////////////////////////////////////////////
    function automatic calc_result_t expected_result(input logic [10:0] op,
                                                     input logic [15:0] a,
                                                     input logic [15:0] b);
        calc_result_t r;
        logic [31:0]  wide_a;
        logic [31:0]  wide_b;
        r      = '0;
        wide_a = {16'd0, a};
        wide_b = {16'd0, b};
        case (op)
            OP_ADD: r.word = wide_a + wide_b;
            OP_SUB: r.word = wide_a - wide_b;
            OP_MUL: r.word = wide_a * wide_b;
            OP_DIV: begin
                r.div.quotient  = (b == 16'd0) ? 16'hFFFF : a / b;
                r.div.remainder = (b == 16'd0) ? a : a % b;
            end
            OP_AND: r.word = wide_a & wide_b;
            OP_OR:  r.word = wide_a | wide_b;
            OP_XOR: r.word = wide_a ^ wide_b;
            OP_NOT: r.word = {16'd0, ~a};
            OP_SHL: r.word = wide_a << b[3:0];
            OP_SHR: r.word = wide_a >> b[3:0];
            OP_CMP: r.word = (a > b) ? 32'd1 : 32'd0;
            default: r.word = 32'd0;  // Not one-hot
        endcase
        return r;
    endfunction

    task automatic abort_run(input string why);
        $display("Done: errors found");
        $fatal(1, "%s", why);
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////
    task automatic press_button();
        @(posedge CLK100MHz);
        btn_c <= 1'b1;
        repeat (12) @(posedge CLK100MHz);  // Well past the debounce latency
        btn_c <= 1'b0;
        repeat (12) @(posedge CLK100MHz);
    endtask

    // Short high bursts, each too short for the debouncer
    task automatic bounce_button(input int toggles);
        repeat (toggles) begin
            @(posedge CLK100MHz);
            btn_c <= 1'b1;
            repeat (2) @(posedge CLK100MHz);
            btn_c <= 1'b0;
        end
        repeat (12) @(posedge CLK100MHz);
    endtask

    task automatic load_a(input logic [15:0] data);
        @(posedge CLK100MHz);
        input_data        <= data;
        operand_selection <= SEL_LOAD_A;
        press_button();
    endtask

    task automatic load_b(input logic [15:0] data);
        @(posedge CLK100MHz);
        input_data        <= data;
        operand_selection <= SEL_LOAD_B;
        press_button();
    endtask

    task automatic compute(input logic [10:0] op);
        @(posedge CLK100MHz);
        operation         <= op;
        operand_selection <= SEL_COMPUTE;
        press_button();
    endtask

    task automatic idle_press(input logic [15:0] data);
        @(posedge CLK100MHz);
        input_data        <= data;
        operand_selection <= SEL_IDLE;
        press_button();
    endtask

    ////////////////////////////////////////////////////////////
    // Compare tasks, sampled on the falling edge
    ////////////////////////////////////////////////////////////
    task automatic check_result(input calc_result_t expected, input logic expected_ready,
                                input string what);
        @(negedge CLK100MHz);
        if (result_out !== expected || result_ready_out !== expected_ready) begin
            $display("Fail at %0t ns: %s, got %h ready %b, expected %h ready %b",
                     $time, what, result_out.word, result_ready_out,
                     expected.word, expected_ready);
            abort_run("result or ready flag mismatch");
        end
    endtask

    task automatic compare_division(input logic [15:0] quotient,
                                    input logic [15:0] remainder);
        @(negedge CLK100MHz);
        if (result_out.div.quotient !== quotient || result_out.div.remainder !== remainder) begin
            $display("Fail at %0t ns: divide got q %h r %h, expected q %h r %h", $time,
                     result_out.div.quotient, result_out.div.remainder, quotient, remainder);
            abort_run("divide fields mismatch");
        end
    endtask

    task automatic check_digit(input int digit, input logic [3:0] expected_nibble);
        logic [7:0] want_an;
        want_an = ~(8'd1 << digit);
        @(negedge CLK100MHz);
        while (an == want_an) @(negedge CLK100MHz);  // Catch the start of the slot
        while (an != want_an) @(negedge CLK100MHz);
        repeat (2) @(posedge CLK100MHz);
        @(negedge CLK100MHz);
        if ($countones(~an) != 1 || an !== want_an
                || seg !== seg_font(expected_nibble)) begin
            $display("Fail at %0t ns: digit %0d shows an %b seg %b, expected an %b seg %b",
                     $time, digit, an, seg, want_an, seg_font(expected_nibble));
            abort_run("display digit mismatch");
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////
    task automatic reset_and_isolation();
        calc_result_t zero;
        zero = '0;
        check_result(zero, 1'b0, "state after reset");
        for (int i = 0; i < 8; i++) begin
            @(posedge CLK100MHz);
            input_data        <= 16'($random(seed));
            operand_selection <= 2'(i);
            operation         <= op_list[i];  // Valid codes, so a stray compute would show
        end
        repeat (8) @(posedge CLK100MHz);
        check_result(zero, 1'b0, "switches moved without a press");
        // Both operands must still be zero
        compute(OP_ADD);
        check_result(expected_result(OP_ADD, 16'd0, 16'd0), 1'b1,
                     "operands changed without a press");
    endtask

    task automatic all_operations();
        logic [15:0]  a;
        logic [15:0]  b;
        calc_result_t want;
        for (int i = 0; i < 11; i++) begin
            a = 16'($random(seed));
            b = 16'($random(seed));
            load_a(a);
            load_b(b);
            compute(op_list[i]);
            want = expected_result(op_list[i], a, b);
            check_result(want, 1'b1, op_names[i]);
            if (op_list[i] == OP_DIV) begin
                compare_division((b == 16'd0) ? 16'hFFFF : a / b, (b == 16'd0) ? a : a % b);
            end
        end
        // Divide by zero
        a = 16'($random(seed));
        load_a(a);
        load_b(16'd0);
        compute(OP_DIV);
        check_result(expected_result(OP_DIV, a, 16'd0), 1'b1, "divide by zero");
        compare_division(16'hFFFF, a);
    endtask

    task automatic once_per_load();
        calc_result_t zero;
        calc_result_t sum;
        zero = '0;
        sum  = expected_result(OP_ADD, 16'h1234, 16'h0011);
        load_a(16'h1234);
        load_b(16'h0011);
        compute(OP_ADD);
        check_result(sum, 1'b1, "first compute");
        compute(OP_SUB);
        check_result(sum, 1'b1, "second compute taken");
        load_b(16'h0022);
        check_result(sum, 1'b0, "new operand keeps ready high");
        compute(OP_ADD | OP_CMP);
        check_result(zero, 1'b0, "operation word not one-hot");
        idle_press(16'hBEEF);
        check_result(zero, 1'b0, "idle press changed state");
        compute(OP_ADD);
        sum = expected_result(OP_ADD, 16'h1234, 16'h0022);
        check_result(sum, 1'b1, "compute after bad operation");
        idle_press(16'h0000);
        check_result(sum, 1'b1, "idle press changed result");
    endtask

    task automatic debounce_glitch();
        calc_result_t kept;
        kept = expected_result(OP_ADD, 16'h1234, 16'h0022);
        @(posedge CLK100MHz);
        input_data        <= 16'h0100;
        operand_selection <= SEL_LOAD_B;
        bounce_button(6);
        check_result(kept, 1'b1, "glitch loaded an operand");
        press_button();
        check_result(kept, 1'b0, "held press did not load");
        compute(OP_ADD);
        check_result(expected_result(OP_ADD, 16'h1234, 16'h0100), 1'b1,
                     "compute after debounced load");
    endtask

    task automatic display_digits();
        calc_result_t shown;
        load_a(16'hFEDC);
        load_b(16'hBA98);
        compute(OP_MUL);
        shown = expected_result(OP_MUL, 16'hFEDC, 16'hBA98);
        check_result(shown, 1'b1, "multiply for display");
        for (int d = 0; d < NUM_DIGITS; d++) begin
            check_digit(d, shown.word[d * 4 +: 4]);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence with watchdog
    ////////////////////////////////////////////////////////////
    initial begin
        seed              = 32'hd3b377d4;
        reset             = 1'b1;
        btn_c             = 1'b0;
        input_data        = 16'd0;
        operand_selection = SEL_IDLE;
        operation         = 11'd0;
        repeat (16) @(posedge CLK100MHz);
        reset <= 1'b0;
        fork
            begin
                reset_and_isolation();
                all_operations();
                once_per_load();
                debounce_glitch();
                display_digits();
            end
            begin
                repeat (WATCHDOG_CYCLES) @(posedge CLK100MHz);
                abort_run("Watchdog expired, the tests did not finish in time");
            end
        join_any
        $display("Done: no errors");
        $finish;
    end

endmodule

// ==== sources.f ====
design/calc_pkg.sv
design/button_debouncer.sv
design/arithmetic_unit.sv
design/hex_display_scan.sv
design/calculator_top.sv
verif/tb_calculator.sv

// ==== Makefile ====
TOP := tb_calculator

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): sources.f design/*.sv verif/*.sv
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f sources.f

lint:
	verilator --lint-only -Wall --top-module calculator_top \
		design/calc_pkg.sv design/button_debouncer.sv design/arithmetic_unit.sv \
		design/hex_display_scan.sv design/calculator_top.sv

clean:
	rm -rf obj_dir
